// File: src.f
+incdir+testbench
logic/issuePkg.sv
logic/warpInstrBuffer.sv
logic/warpScoreboard.sv
logic/issueArbiter.sv
logic/warpIssueTop.sv
testbench/warpIssueTb.sv

// File: testbench/issueVectors.svh
////////////////////////////////////////////////////////////
// step table types
////////////////////////////////////////////////////////////
typedef struct packed {
    logic                  valid;
    logic [warpIdW-1:0]    warp;
    // low bits of the instruction word, the rest is random
    logic [5:0]            tag;
    logic [regIdW-1:0]     src1;
    logic [regIdW-1:0]     src2;
    logic [regIdW-1:0]     dst;
    // src1Valid src2Valid regWrite memRead memWrite
    logic [4:0]            flags;
    logic [numThreads-1:0] mask;
} decT;

typedef struct packed {
    logic               valid;
    logic [warpIdW-1:0] warp;
    logic [scbIdW-1:0]  id;
} wbT;

typedef struct packed {
    logic                  valid;
    logic [warpIdW-1:0]    warp;
    logic                  zero;
    logic [numThreads-1:0] mask;
} fbT;

// expected issue, valid low means the port stays idle
typedef struct packed {
    logic                  valid;
    logic [warpIdW-1:0]    warp;
    logic [5:0]            tag;
    logic [numThreads-1:0] mask;
    logic                  replay;
    logic [scbIdW-1:0]     scbId;
} expT;

typedef struct packed {
    logic [3:0]          test;
    logic                ocFull;
    decT                 dec;
    wbT                  wb;
    fbT                  fb;
    expT                 want;
    logic                chkFetch;
    logic [numWarps-1:0] fetch;
} stepT;

localparam int aluFlags  = 'b11100;
localparam int loadFlags = 'b10110;
localparam int noChk     = -1;

localparam decT noDecode = '0;
localparam wbT  noWb     = '0;
localparam fbT  noFb     = '0;
localparam expT noIssue  = '0;

stepT steps [$];

function automatic decT decode(int w, int tag, int s1, int s2, int d, int flags, int mask);
    decT r;
    r.valid = 1'b1;
    r.warp  = warpIdW'(w);
    r.tag   = 6'(tag);
    r.src1  = regIdW'(s1);
    r.src2  = regIdW'(s2);
    r.dst   = regIdW'(d);
    r.flags = 5'(flags);
    r.mask  = numThreads'(mask);
    return r;
endfunction

function automatic wbT writeback(int w, int id);
    wbT r;
    r.valid = 1'b1;
    r.warp  = warpIdW'(w);
    r.id    = scbIdW'(id);
    return r;
endfunction

function automatic fbT feedback(int w, int zero, int mask);
    fbT r;
    r.valid = 1'b1;
    r.warp  = warpIdW'(w);
    r.zero  = zero[0];
    r.mask  = numThreads'(mask);
    return r;
endfunction

function automatic expT expectIssue(int w, int tag, int mask, int rpl, int scb);
    expT r;
    r.valid  = 1'b1;
    r.warp   = warpIdW'(w);
    r.tag    = 6'(tag);
    r.mask   = numThreads'(mask);
    r.replay = rpl[0];
    r.scbId  = scbIdW'(scb);
    return r;
endfunction

task automatic addStep(int test, int oc, decT d, wbT w, fbT f, expT want, int fetchChk);
    stepT s;
    s.test     = 4'(test);
    s.ocFull   = oc[0];
    s.dec      = d;
    s.wb       = w;
    s.fb       = f;
    s.want     = want;
    s.chkFetch = fetchChk >= 0;
    s.fetch    = numWarps'(fetchChk);
    steps.push_back(s);
endtask

////////////////////////////////////////////////////////////
// the table, one step per row
////////////////////////////////////////////////////////////
task automatic loadTable();
    // fill warp 0 behind a full collector, then drain in order
    addStep(1, 0, decode(0, 1, 10, 11, 1, aluFlags, 'h11), noWb, noFb, noIssue, 'b11);
    addStep(1, 1, decode(0, 2, 12, 13, 2, aluFlags, 'h22), noWb, noFb, noIssue, noChk);
    addStep(1, 1, decode(0, 3, 10, 11, 3, aluFlags, 'h44), noWb, noFb, noIssue, noChk);
    addStep(1, 1, decode(0, 4, 10, 11, 4, aluFlags, 'h88), noWb, noFb, noIssue, 'b10);
    addStep(1, 1, noDecode, noWb, noFb, noIssue, 'b10);
    addStep(1, 0, noDecode, noWb, noFb, expectIssue(0, 1, 'h11, 0, 0), noChk);
    addStep(1, 0, noDecode, noWb, noFb, expectIssue(0, 2, 'h22, 0, 1), noChk);
    addStep(1, 0, noDecode, noWb, noFb, expectIssue(0, 3, 'h44, 0, 2), noChk);
    addStep(1, 0, noDecode, noWb, noFb, expectIssue(0, 4, 'h88, 0, 3), 'b11);
    // warp 1 alone first so warp 0 is preferred next
    addStep(2, 0, decode(1, 5, 10, 11, 9, aluFlags, 'h80), writeback(0, 0), noFb,
            expectIssue(1, 5, 'h80, 0, 0), noChk);
    addStep(2, 1, decode(0, 6, 10, 11, 5, aluFlags, 'h01), writeback(0, 1), noFb,
            noIssue, noChk);
    addStep(2, 1, decode(0, 7, 10, 11, 6, aluFlags, 'h02), writeback(0, 2), noFb,
            noIssue, noChk);
    addStep(2, 1, decode(1, 8, 10, 11, 7, aluFlags, 'h04), writeback(0, 3), noFb,
            noIssue, noChk);
    addStep(2, 1, decode(1, 9, 10, 11, 8, aluFlags, 'h08), noWb, noFb, noIssue, noChk);
    addStep(2, 0, noDecode, noWb, noFb, expectIssue(0, 6, 'h01, 0, 0), noChk);
    addStep(2, 0, noDecode, noWb, noFb, expectIssue(1, 8, 'h04, 0, 1), noChk);
    addStep(2, 0, noDecode, noWb, noFb, expectIssue(0, 7, 'h02, 0, 1), noChk);
    addStep(2, 0, noDecode, noWb, noFb, expectIssue(1, 9, 'h08, 0, 2), noChk);
    // r12 pending until scoreboard entry 0 of warp 0 is written back
    addStep(3, 0, decode(0, 10, 10, 11, 12, aluFlags, 'hFF), writeback(0, 0), noFb,
            expectIssue(0, 10, 'hFF, 0, 0), noChk);
    addStep(3, 0, decode(0, 11, 12, 11, 13, aluFlags, 'h3C), writeback(0, 1), noFb,
            noIssue, noChk);
    addStep(3, 0, noDecode, writeback(1, 0), noFb, noIssue, noChk);
    addStep(3, 0, noDecode, writeback(1, 1), noFb, noIssue, noChk);
    addStep(3, 0, noDecode, writeback(0, 0), noFb, noIssue, noChk);
    addStep(3, 0, noDecode, writeback(1, 2), noFb, expectIssue(0, 11, 'h3C, 0, 0), noChk);
    addStep(3, 0, noDecode, writeback(0, 0), noFb, noIssue, noChk);
    // miss on a load, reissue ahead of the younger ALU op
    addStep(4, 0, decode(0, 12, 10, 0, 14, loadFlags, 'hFF), noWb, noFb,
            expectIssue(0, 12, 'hFF, 0, 0), noChk);
    addStep(4, 0, decode(0, 13, 10, 11, 15, aluFlags, 'h0F), noWb, feedback(0, 1, 0),
            expectIssue(0, 12, 'hFF, 1, 0), noChk);
    addStep(4, 0, noDecode, noWb, noFb, expectIssue(0, 13, 'h0F, 0, 1), noChk);
    addStep(4, 0, noDecode, writeback(0, 1), feedback(0, 0, 'hFF), noIssue, noChk);
    // half the threads served, then the rest
    addStep(5, 0, decode(1, 14, 10, 0, 16, loadFlags, 'hFF), noWb, noFb,
            expectIssue(1, 14, 'hFF, 0, 0), noChk);
    addStep(5, 0, decode(1, 15, 16, 11, 17, aluFlags, 'h55), noWb, feedback(1, 0, 'h0F),
            expectIssue(1, 14, 'hF0, 1, 0), noChk);
    addStep(5, 0, noDecode, noWb, noFb, noIssue, noChk);
    addStep(5, 0, noDecode, noWb, feedback(1, 0, 'hF0), noIssue, noChk);
    addStep(5, 0, noDecode, noWb, noFb, expectIssue(1, 15, 'h55, 0, 0), noChk);
    addStep(5, 0, noDecode, writeback(1, 0), noFb, noIssue, noChk);
    // hold the collector full with both warps ready
    addStep(6, 1, decode(0, 16, 10, 11, 18, aluFlags, 'hA5), noWb, noFb, noIssue, noChk);
    addStep(6, 1, decode(1, 17, 10, 11, 19, aluFlags, 'h5A), noWb, noFb, noIssue, noChk);
    addStep(6, 1, noDecode, noWb, noFb, noIssue, noChk);
    addStep(6, 1, noDecode, noWb, noFb, noIssue, noChk);
    addStep(6, 0, noDecode, noWb, noFb, expectIssue(0, 16, 'hA5, 0, 0), noChk);
    addStep(6, 0, noDecode, noWb, noFb, expectIssue(1, 17, 'h5A, 0, 0), noChk);
endtask

// File: testbench/warpIssueTb.sv
`timescale 1ns/1ns
`default_nettype none

module warpIssueTb import issuePkg::*; ();

`include "issueVectors.svh"

    logic                  clk;
    logic                  rst;
    logic                  decValid;
    logic [warpIdW-1:0]    decWarp;
    logic [31:0]           decInstr;
    logic [regIdW-1:0]     decSrc1;
    logic [regIdW-1:0]     decSrc2;
    logic [regIdW-1:0]     decDst;
    logic                  decSrc1Valid;
    logic                  decSrc2Valid;
    logic                  decRegWrite;
    logic                  decMemRead;
    logic                  decMemWrite;
    logic [3:0]            decAluOp;
    logic [numThreads-1:0] decMask;
    logic [numWarps-1:0]   fetchReq;
    logic                  ocFull;
    logic                  issueValid;
    logic [warpIdW-1:0]    issueWarp;
    issuePacketT           issuePacket;
    logic                  wbValid;
    logic [warpIdW-1:0]    wbWarp;
    logic [scbIdW-1:0]     wbScbId;
    logic                  fbValid;
    logic [warpIdW-1:0]    fbWarp;
    logic                  fbZero;
    logic [numThreads-1:0] fbMask;

    // random upper bits of each instruction word, by tag
    logic [25:0] randHi [64];

    // decoded fields by tag, for the rest of the payload
    decT decByTag [64];

    int errors      = 0;
    int testErrors  = 0;
    int testsRun    = 0;
    int testsFailed = 0;

    warpIssueTop u_warpIssueTop (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] instrWord(logic [5:0] tag);
        return {randHi[tag], tag};
    endfunction

    function automatic string testName(logic [3:0] t);
        case (t)
            4'd1: return "reset and queue limit";
            4'd2: return "round robin";
            4'd3: return "dependency";
            4'd4: return "replay after miss";
            4'd5: return "partial service";
            4'd6: return "back-pressure";
            default: return "unknown";
        endcase
    endfunction

    task automatic applyStep(stepT s);
        decValid = s.dec.valid;
        decWarp  = s.dec.warp;
        decInstr = instrWord(s.dec.tag);
        decSrc1  = s.dec.src1;
        decSrc2  = s.dec.src2;
        decDst   = s.dec.dst;
        {decSrc1Valid, decSrc2Valid, decRegWrite, decMemRead, decMemWrite} = s.dec.flags;
        decAluOp = s.dec.tag[3:0];
        decMask  = s.dec.mask;
        wbValid  = s.wb.valid;
        wbWarp   = s.wb.warp;
        wbScbId  = s.wb.id;
        fbValid  = s.fb.valid;
        fbWarp   = s.fb.warp;
        fbZero   = s.fb.zero;
        fbMask   = s.fb.mask;
        ocFull   = s.ocFull;
        if (s.dec.valid) begin
            decByTag[s.dec.tag] = s.dec;
        end
    endtask

    // strobes last one cycle, ocFull holds
    task automatic clearStrobes();
        decValid = 1'b0;
        wbValid  = 1'b0;
        fbValid  = 1'b0;
    endtask

    task automatic reportValue(int step, string name, logic [31:0] got, logic [31:0] want);
        $display("error step %0d %s: got %h, expected %h", step, name, got, want);
        errors++;
        testErrors++;
    endtask

    task automatic compareIssue(int step, expT w);
        logic [31:0] expInstr;
        decT         d;
        logic [4:0]  pktFlags;
        expInstr = instrWord(w.tag);
        d        = decByTag[w.tag];
        pktFlags = {issuePacket.src1Valid, issuePacket.src2Valid, issuePacket.regWrite,
                    issuePacket.memRead, issuePacket.memWrite};
        if (issueWarp !== w.warp)
            reportValue(step, "issueWarp", 32'(issueWarp), 32'(w.warp));
        if (issuePacket.instr !== expInstr)
            reportValue(step, "instr", issuePacket.instr, expInstr);
        if (issuePacket.activeMask !== w.mask)
            reportValue(step, "activeMask", 32'(issuePacket.activeMask), 32'(w.mask));
        if (issuePacket.replay !== w.replay)
            reportValue(step, "replay", 32'(issuePacket.replay), 32'(w.replay));
        if (issuePacket.scbId !== w.scbId)
            reportValue(step, "scbId", 32'(issuePacket.scbId), 32'(w.scbId));
        if (issuePacket.src1 !== d.src1)
            reportValue(step, "src1", 32'(issuePacket.src1), 32'(d.src1));
        if (issuePacket.src2 !== d.src2)
            reportValue(step, "src2", 32'(issuePacket.src2), 32'(d.src2));
        if (issuePacket.dst !== d.dst)
            reportValue(step, "dst", 32'(issuePacket.dst), 32'(d.dst));
        if (pktFlags !== d.flags)
            reportValue(step, "flags", 32'(pktFlags), 32'(d.flags));
        if (issuePacket.aluOp !== d.tag[3:0])
            reportValue(step, "aluOp", 32'(issuePacket.aluOp), 32'(d.tag[3:0]));
    endtask

    task automatic reportTest(logic [3:0] t);
        testsRun++;
        if (testErrors == 0) begin
            $display("test %0d %s: ok", t, testName(t));
        end else begin
            testsFailed++;
            $display("test %0d %s: %0d errors", t, testName(t), testErrors);
        end
        testErrors = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial begin
        stepT       s;
        logic [3:0] curTest;
        int         waitCycles;

        void'($urandom(32'hb02e_927b));
        foreach (randHi[i]) begin
            randHi[i] = 26'($urandom);
        end
        rst = 1'b0;
        applyStep('0);
        loadTable();
        repeat (10) @(posedge clk);
        #2 rst = 1'b1;

        curTest = steps[0].test;
        foreach (steps[i]) begin
            s = steps[i];
            if (s.test != curTest) begin
                reportTest(curTest);
                curTest = s.test;
            end
            @(posedge clk);
            #2;
            applyStep(s);
            // outputs settle well before the falling edge
            @(negedge clk);
            if (s.chkFetch && fetchReq !== s.fetch)
                reportValue(i, "fetchReq", 32'(fetchReq), 32'(s.fetch));
            if (s.want.valid) begin
                waitCycles = 0;
                while (issueValid !== 1'b1 && waitCycles < 20) begin
                    @(posedge clk);
                    #2;
                    clearStrobes();
                    @(negedge clk);
                    waitCycles++;
                end
                if (issueValid !== 1'b1) begin
                    $display("step %0d: no issue seen within 20 cycles", i);
                    errors++;
                    testErrors++;
                end else begin
                    compareIssue(i, s.want);
                end
            end else if (issueValid !== 1'b0) begin
                reportValue(i, "issueValid", 32'(issueValid), 32'h0);
            end
        end
        reportTest(curTest);

        $display("%0d tests, %0d failed, %0d errors", testsRun, testsFailed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/warpIssueTop.sv
`timescale 1ns/1ns
`default_nettype none

module warpIssueTop import issuePkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    // decode
    input  wire                  decValid,
    input  wire [warpIdW-1:0]    decWarp,
    input  wire [31:0]           decInstr,
    input  wire [regIdW-1:0]     decSrc1,
    input  wire [regIdW-1:0]     decSrc2,
    input  wire [regIdW-1:0]     decDst,
    input  wire                  decSrc1Valid,
    input  wire                  decSrc2Valid,
    input  wire                  decRegWrite,
    input  wire                  decMemRead,
    input  wire                  decMemWrite,
    input  wire [3:0]            decAluOp,
    input  wire [numThreads-1:0] decMask,
    output logic [numWarps-1:0]  fetchReq,

    // operand collector
    input  wire                  ocFull,
    output logic                 issueValid,
    output logic [warpIdW-1:0]   issueWarp,
    output issuePacketT          issuePacket,

    // writeback and memory feedback
    input  wire                  wbValid,
    input  wire [warpIdW-1:0]    wbWarp,
    input  wire [scbIdW-1:0]     wbScbId,
    input  wire                  fbValid,
    input  wire [warpIdW-1:0]    fbWarp,
    input  wire                  fbZero,
    input  wire [numThreads-1:0] fbMask
);

    logic [numWarps-1:0] decEn;
    logic [numWarps-1:0] wbEn;
    logic [numWarps-1:0] fbEn;
    logic [numWarps-1:0] bufReq;
    logic [numWarps-1:0] bufGrant;
    issuePacketT         bufPkt [numWarps];

    // buffer to scoreboard, per warp
    logic [regIdW-1:0]   hzSrc1 [numWarps];
    logic [regIdW-1:0]   hzSrc2 [numWarps];
    logic [regIdW-1:0]   hzDst  [numWarps];
    logic [numWarps-1:0] hzSrc1V;
    logic [numWarps-1:0] hzSrc2V;
    logic [numWarps-1:0] hzDstV;
    logic [numWarps-1:0] scbAlloc;
    logic [numWarps-1:0] scbMemOp;
    logic [numWarps-1:0] scbFull;
    logic [numWarps-1:0] scbDep;
    logic [scbIdW-1:0]   scbId  [numWarps];
    logic [numWarps-1:0] rplDone;
    logic [scbIdW-1:0]   rplScbId [numWarps];

    // per-warp strobes, data buses fan out
    always_comb begin
        decEn = '0;
        wbEn  = '0;
        fbEn  = '0;
        decEn[decWarp] = decValid;
        wbEn[wbWarp]   = wbValid;
        fbEn[fbWarp]   = fbValid;
    end

    assign scbMemOp[0] = bufPkt[0].memRead | bufPkt[0].memWrite;
    assign scbMemOp[1] = bufPkt[1].memRead | bufPkt[1].memWrite;

    ////////////////////////////////////////////////////////////
    // warp 0
    ////////////////////////////////////////////////////////////
    warpInstrBuffer u_buf0 (
        .clk, .rst, .wrEn(decEn[0]),
        .instr(decInstr), .src1(decSrc1), .src2(decSrc2), .dst(decDst),
        .src1Valid(decSrc1Valid), .src2Valid(decSrc2Valid), .regWrite(decRegWrite),
        .memRead(decMemRead), .memWrite(decMemWrite), .aluOp(decAluOp),
        .activeMask(decMask), .fetchReq(fetchReq[0]),
        .scbFull(scbFull[0]), .scbDependent(scbDep[0]), .allocScbId(scbId[0]),
        .scbSrc1(hzSrc1[0]), .scbSrc2(hzSrc2[0]), .scbDst(hzDst[0]),
        .scbSrc1Valid(hzSrc1V[0]), .scbSrc2Valid(hzSrc2V[0]), .scbDstValid(hzDstV[0]),
        .allocate(scbAlloc[0]), .replayDone(rplDone[0]), .replayScbId(rplScbId[0]),
        .fbValid(fbEn[0]), .fbZero, .fbMask,
        .issueReq(bufReq[0]), .issuePacket(bufPkt[0]), .issueGrant(bufGrant[0])
    );

    warpScoreboard u_scb0 (
        .clk, .rst,
        .src1(hzSrc1[0]), .src2(hzSrc2[0]), .dst(hzDst[0]),
        .src1Valid(hzSrc1V[0]), .src2Valid(hzSrc2V[0]), .dstValid(hzDstV[0]),
        .allocate(scbAlloc[0]), .memOp(scbMemOp[0]),
        .full(scbFull[0]), .dependent(scbDep[0]), .allocScbId(scbId[0]),
        .wbValid(wbEn[0]), .wbScbId,
        .replayDone(rplDone[0]), .replayScbId(rplScbId[0])
    );

    ////////////////////////////////////////////////////////////
    // warp 1
    ////////////////////////////////////////////////////////////
    warpInstrBuffer u_buf1 (
        .clk, .rst, .wrEn(decEn[1]),
        .instr(decInstr), .src1(decSrc1), .src2(decSrc2), .dst(decDst),
        .src1Valid(decSrc1Valid), .src2Valid(decSrc2Valid), .regWrite(decRegWrite),
        .memRead(decMemRead), .memWrite(decMemWrite), .aluOp(decAluOp),
        .activeMask(decMask), .fetchReq(fetchReq[1]),
        .scbFull(scbFull[1]), .scbDependent(scbDep[1]), .allocScbId(scbId[1]),
        .scbSrc1(hzSrc1[1]), .scbSrc2(hzSrc2[1]), .scbDst(hzDst[1]),
        .scbSrc1Valid(hzSrc1V[1]), .scbSrc2Valid(hzSrc2V[1]), .scbDstValid(hzDstV[1]),
        .allocate(scbAlloc[1]), .replayDone(rplDone[1]), .replayScbId(rplScbId[1]),
        .fbValid(fbEn[1]), .fbZero, .fbMask,
        .issueReq(bufReq[1]), .issuePacket(bufPkt[1]), .issueGrant(bufGrant[1])
    );

    warpScoreboard u_scb1 (
        .clk, .rst,
        .src1(hzSrc1[1]), .src2(hzSrc2[1]), .dst(hzDst[1]),
        .src1Valid(hzSrc1V[1]), .src2Valid(hzSrc2V[1]), .dstValid(hzDstV[1]),
        .allocate(scbAlloc[1]), .memOp(scbMemOp[1]),
        .full(scbFull[1]), .dependent(scbDep[1]), .allocScbId(scbId[1]),
        .wbValid(wbEn[1]), .wbScbId,
        .replayDone(rplDone[1]), .replayScbId(rplScbId[1])
    );

    // shared issue port
    issueArbiter #(
        .payloadT(issuePacketT)
    ) u_arb (
        .clk, .rst, .ocFull,
        .req(bufReq), .payloadIn(bufPkt), .grant(bufGrant),
        .issueValid, .issueWarp, .issuePayload(issuePacket)
    );

endmodule

`default_nettype wire

// File: logic/issueArbiter.sv
`timescale 1ns/1ns
`default_nettype none

module issueArbiter import issuePkg::*; #(
    parameter type payloadT = logic
) (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 ocFull,
    input  wire [numWarps-1:0]  req,
    input  wire payloadT        payloadIn [numWarps],
    output logic [numWarps-1:0] grant,
    output logic                issueValid,
    output logic [warpIdW-1:0]  issueWarp,
    output payloadT             issuePayload
);

    // warp preferred in the next contested cycle
    logic [warpIdW-1:0] prio;
    logic [warpIdW-1:0] other;
    logic [warpIdW-1:0] win;
    logic               any;

    assign other = prio + 1'b1;

    always_comb begin
        win = prio;
        any = 1'b0;
        if (!ocFull) begin
            if (req[prio]) begin
                win = prio;
                any = 1'b1;
            end else if (req[other]) begin
                win = other;
                any = 1'b1;
            end
        end
    end

    always_comb begin
        grant = '0;
        if (any) begin
            grant[win] = 1'b1;
        end
    end

    assign issueValid   = any;
    assign issueWarp    = win;
    assign issuePayload = payloadIn[win];

    // rotate past the winner
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            prio <= '0;
        end else if (any) begin
            prio <= win + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: logic/warpScoreboard.sv
`timescale 1ns/1ns
`default_nettype none

module warpScoreboard import issuePkg::*; (
    input  wire               clk,
    input  wire               rst,

    // hazard check on the buffer head
    input  wire [regIdW-1:0]  src1,
    input  wire [regIdW-1:0]  src2,
    input  wire [regIdW-1:0]  dst,
    input  wire               src1Valid,
    input  wire               src2Valid,
    input  wire               dstValid,

    // allocation
    input  wire               allocate,
    input  wire               memOp,
    output logic              full,
    output logic              dependent,
    output logic [scbIdW-1:0] allocScbId,

    // clearing
    input  wire               wbValid,
    input  wire [scbIdW-1:0]  wbScbId,
    input  wire               replayDone,
    input  wire [scbIdW-1:0]  replayScbId
);

    logic [scbDepth-1:0] entValid;
    logic [scbDepth-1:0] entWr;
    logic [scbDepth-1:0] entMem;
    logic [regIdW-1:0]   entDst [scbDepth];

    assign full = &entValid;

    // lowest free index
    always_comb begin
        allocScbId = '0;
        for (int i = scbDepth - 1; i >= 0; i--) begin
            if (!entValid[i]) begin
                allocScbId = scbIdW'(i);
            end
        end
    end

    // RAW on either source, WAW on the destination
    always_comb begin
        dependent = 1'b0;
        for (int i = 0; i < scbDepth; i++) begin
            if (entValid[i] && entWr[i]) begin
                if ((src1Valid && src1 == entDst[i]) ||
                    (src2Valid && src2 == entDst[i]) ||
                    (dstValid && dst == entDst[i])) begin
                    dependent = 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            entValid <= '0;
        end else begin
            if (allocate) begin
                entValid[allocScbId] <= 1'b1;
            end
            // memory entries wait for the last replay instead
            if (wbValid && !entMem[wbScbId]) begin
                entValid[wbScbId] <= 1'b0;
            end
            if (replayDone && entMem[replayScbId]) begin
                entValid[replayScbId] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (allocate) begin
            entDst[allocScbId] <= dst;
            entWr[allocScbId]  <= dstValid;
            entMem[allocScbId] <= memOp;
        end
    end

endmodule

`default_nettype wire

// File: logic/warpInstrBuffer.sv
`timescale 1ns/1ns
`default_nettype none

module warpInstrBuffer import issuePkg::*; (
    input  wire                  clk,
    input  wire                  rst,

    // decoded instruction
    input  wire                  wrEn,
    input  wire [31:0]           instr,
    input  wire [regIdW-1:0]     src1,
    input  wire [regIdW-1:0]     src2,
    input  wire [regIdW-1:0]     dst,
    input  wire                  src1Valid,
    input  wire                  src2Valid,
    input  wire                  regWrite,
    input  wire                  memRead,
    input  wire                  memWrite,
    input  wire [3:0]            aluOp,
    input  wire [numThreads-1:0] activeMask,
    output logic                 fetchReq,

    // scoreboard
    input  wire                  scbFull,
    input  wire                  scbDependent,
    input  wire [scbIdW-1:0]     allocScbId,
    output logic [regIdW-1:0]    scbSrc1,
    output logic [regIdW-1:0]    scbSrc2,
    output logic [regIdW-1:0]    scbDst,
    output logic                 scbSrc1Valid,
    output logic                 scbSrc2Valid,
    output logic                 scbDstValid,
    output logic                 allocate,
    output logic                 replayDone,
    output logic [scbIdW-1:0]    replayScbId,

    // memory feedback
    input  wire                  fbValid,
    input  wire                  fbZero,
    input  wire [numThreads-1:0] fbMask,

    // arbiter
    output logic                 issueReq,
    output issuePacketT          issuePacket,
    input  wire                  issueGrant
);

    // entry payload
    logic [31:0]           instrArr    [ibDepth];
    logic [regIdW-1:0]     src1Arr     [ibDepth];
    logic [regIdW-1:0]     src2Arr     [ibDepth];
    logic [regIdW-1:0]     dstArr      [ibDepth];
    logic [3:0]            aluOpArr    [ibDepth];
    logic [numThreads-1:0] maskArr     [ibDepth];
    logic [scbIdW-1:0]     scbIdArr    [ibDepth];
    logic [ibDepth-1:0]    src1VArr;
    logic [ibDepth-1:0]    src2VArr;
    logic [ibDepth-1:0]    regWriteArr;
    logic [ibDepth-1:0]    memReadArr;
    logic [ibDepth-1:0]    memWriteArr;

    // entry control
    logic [ibDepth-1:0]    validArr;
    logic [ibDepth-1:0]    replayArr;
    logic [ibDepth-1:0]    validNext;
    logic [ibDepth-1:0]    replayNext;

    logic [ibPtrW-1:0]     wrPtr;
    logic [ibPtrW-1:0]     issPtr;
    logic [ibPtrW-1:0]     rplPtr;
    logic [ibPtrW-1:0]     issPtrNext;
    logic [ibPtrW-1:0]     depth;
    logic [ibPtrW-2:0]     wrIdx;
    logic [ibPtrW-2:0]     issIdx;
    logic [ibPtrW-2:0]     rplIdx;
    logic [ibPtrW-2:0]     selIdx;

    logic                  headValid;
    logic                  headMem;
    logic                  rplOut;
    logic                  rplReq;
    logic                  newReq;
    logic                  newGrant;
    logic                  rplGrant;
    logic                  fbHit;
    logic                  fbDone;
    logic [numThreads-1:0] maskNext;

    assign wrIdx  = wrPtr[ibPtrW-2:0];
    assign issIdx = issPtr[ibPtrW-2:0];
    assign rplIdx = rplPtr[ibPtrW-2:0];

    // occupancy counts retained memory entries too
    assign depth    = wrPtr - rplPtr;
    assign fetchReq = (int'(depth) + int'(wrEn)) < ibDepth;

    ////////////////////////////////////////////////////////////
    // request generation
    ////////////////////////////////////////////////////////////
    assign headValid = issPtr != wrPtr;
    assign headMem   = memReadArr[issIdx] | memWriteArr[issIdx];

    // an issued memory instruction still waiting on feedback
    assign rplOut = (rplPtr != issPtr) & validArr[rplIdx];
    assign rplReq = rplOut & replayArr[rplIdx];

    // younger memory op holds behind the outstanding one
    assign newReq = !rplReq & headValid & !scbFull & !scbDependent & !(rplOut & headMem);

    assign issueReq = rplReq | newReq;
    assign newGrant = newReq & issueGrant;
    assign rplGrant = rplReq & issueGrant;

    ////////////////////////////////////////////////////////////
    // memory feedback
    ////////////////////////////////////////////////////////////
    assign fbHit    = fbValid & rplOut;
    assign maskNext = maskArr[rplIdx] & ~fbMask;
    assign fbDone   = fbHit & !fbZero & (maskNext == '0);

    always_comb begin
        validNext  = validArr;
        replayNext = replayArr;
        if (wrEn) begin
            validNext[wrIdx]  = 1'b1;
            replayNext[wrIdx] = 1'b0;
        end
        // non-memory entries leave at issue
        if (newGrant && !headMem) begin
            validNext[issIdx] = 1'b0;
        end
        if (rplGrant) begin
            replayNext[rplIdx] = 1'b0;
        end
        if (fbHit && !fbDone) begin
            replayNext[rplIdx] = 1'b1;
        end
        if (fbDone) begin
            validNext[rplIdx] = 1'b0;
        end
    end

    assign issPtrNext = issPtr + ibPtrW'(newGrant);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            wrPtr     <= '0;
            issPtr    <= '0;
            rplPtr    <= '0;
            validArr  <= '0;
            replayArr <= '0;
        end else begin
            wrPtr     <= wrPtr + ibPtrW'(wrEn);
            issPtr    <= issPtrNext;
            // replay pointer parks on the oldest live memory entry
            rplPtr    <= validNext[rplIdx] ? rplPtr : issPtrNext;
            validArr  <= validNext;
            replayArr <= replayNext;
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            instrArr[wrIdx]    <= instr;
            src1Arr[wrIdx]     <= src1;
            src2Arr[wrIdx]     <= src2;
            dstArr[wrIdx]      <= dst;
            aluOpArr[wrIdx]    <= aluOp;
            maskArr[wrIdx]     <= activeMask;
            src1VArr[wrIdx]    <= src1Valid;
            src2VArr[wrIdx]    <= src2Valid;
            regWriteArr[wrIdx] <= regWrite;
            memReadArr[wrIdx]  <= memRead;
            memWriteArr[wrIdx] <= memWrite;
        end
        // served threads drop out of the private mask
        if (fbHit && !fbZero) begin
            maskArr[rplIdx] <= maskNext;
        end
        if (newGrant) begin
            scbIdArr[issIdx] <= allocScbId;
        end
    end

    ////////////////////////////////////////////////////////////
    // issue payload and scoreboard side
    ////////////////////////////////////////////////////////////
    assign selIdx = rplReq ? rplIdx : issIdx;

    always_comb begin
        issuePacket.instr      = instrArr[selIdx];
        issuePacket.src1       = src1Arr[selIdx];
        issuePacket.src2       = src2Arr[selIdx];
        issuePacket.dst        = dstArr[selIdx];
        issuePacket.src1Valid  = src1VArr[selIdx];
        issuePacket.src2Valid  = src2VArr[selIdx];
        issuePacket.regWrite   = regWriteArr[selIdx];
        issuePacket.memRead    = memReadArr[selIdx];
        issuePacket.memWrite   = memWriteArr[selIdx];
        issuePacket.aluOp      = aluOpArr[selIdx];
        issuePacket.activeMask = maskArr[selIdx];
        // a reissue keeps the entry it got at first issue
        issuePacket.scbId      = rplReq ? scbIdArr[rplIdx] : allocScbId;
        issuePacket.replay     = rplReq;
    end

    assign scbSrc1      = src1Arr[issIdx];
    assign scbSrc2      = src2Arr[issIdx];
    assign scbDst       = dstArr[issIdx];
    assign scbSrc1Valid = src1VArr[issIdx];
    assign scbSrc2Valid = src2VArr[issIdx];
    assign scbDstValid  = regWriteArr[issIdx];
    assign allocate     = newGrant;
    assign replayDone   = fbDone;
    assign replayScbId  = scbIdArr[rplIdx];

endmodule

`default_nettype wire

// File: logic/issuePkg.sv
`default_nettype none

package issuePkg;

    ////////////////////////////////////////////////////////////
    // core dimensions
    ////////////////////////////////////////////////////////////
    localparam int numThreads = 8;
    localparam int numWarps   = 2;
    localparam int warpIdW    = 1;

    // instruction buffer, pointers carry one wrap bit
    localparam int ibDepth = 4;
    localparam int ibPtrW  = 3;

    localparam int scbDepth = 4;
    localparam int scbIdW   = 2;

    localparam int regIdW = 5;

    // payload handed to the operand collector
    typedef struct packed {
        logic [31:0]           instr;
        logic [regIdW-1:0]     src1;
        logic [regIdW-1:0]     src2;
        logic [regIdW-1:0]     dst;
        logic                  src1Valid;
        logic                  src2Valid;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic [3:0]            aluOp;
        logic [numThreads-1:0] activeMask;
        logic [scbIdW-1:0]     scbId;
        // set on a reissue of a memory instruction
        logic                  replay;
    } issuePacketT;

endpackage

`default_nettype wire
